// File: include/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// memory geometry, 32-bit words
`define MEM_DEPTH_WORDS 256
`define MEM_IDX_W 8  // word index = addr[9:2]

// grant to done
// request cycle plus one delay cycle
`define MEM_READ_LATENCY 2

// one-hot write length codes
`define WLEN_BYTE 3'b001
`define WLEN_HALF 3'b010
`define WLEN_WORD 3'b100

`endif

// File: source/mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

    // one memory word, seen whole or by byte lane
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;  // lane 0 = addr offset 0
    } mem_word_u;

    // request from the arbiter to the memory
    typedef struct packed {
        logic [`MEM_IDX_W-1:0] idx;    // word index
        logic                  we;     // 1 = write
        logic [3:0]            wstrb;  // byte lanes to write
        mem_word_u             wdata;  // data already in its lanes
    } mem_req_t;

    // read response
    typedef struct packed {
        logic        done;  // high one cycle per read
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage

// File: source/sram_bank.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module sram_bank (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid,
    input  mem_pkg::mem_req_t req_pkt,
    output mem_pkg::mem_rsp_t rsp
);
    import mem_pkg::*;

    localparam int LAT = `MEM_READ_LATENCY;

    mem_word_u mem [`MEM_DEPTH_WORDS];

    logic [LAT-1:0] pipe_v;        // read tag per stage
    mem_word_u      pipe_d [LAT];  // read word per stage
    logic           rd_go;

    assign rd_go = valid & ~req_pkt.we;

    // ====================
    // write port
    // ====================
    always_ff @(posedge clk) begin
        if (valid && req_pkt.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req_pkt.wstrb[b]) begin
                    mem[req_pkt.idx].bytes[b] <= req_pkt.wdata.bytes[b];  // merge by lane
                end
            end
        end
    end

    // ====================
    // read pipeline
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            pipe_v <= '0;
        end else begin
            pipe_v[0] <= rd_go;
            for (int i = 1; i < LAT; i++) begin
                pipe_v[i] <= pipe_v[i-1];
            end
        end
    end

    // reads can overlap, one new word per cycle
    always_ff @(posedge clk) begin
        if (rd_go) begin
            pipe_d[0] <= mem[req_pkt.idx];
        end
        for (int i = 1; i < LAT; i++) begin
            pipe_d[i] <= pipe_d[i-1];
        end
    end

    assign rsp.done  = pipe_v[LAT-1];
    assign rsp.rdata = pipe_d[LAT-1].word;

endmodule

// File: source/mem_arbiter.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_arbiter (
    input  logic              clk,
    input  logic              rst,

    // fetch client
    input  logic              f_req,
    input  mem_pkg::mem_req_t f_pkt,
    output logic              f_gnt,
    output mem_pkg::mem_rsp_t f_rsp,

    // data client
    input  logic              d_req,
    input  mem_pkg::mem_req_t d_pkt,
    output logic              d_gnt,
    output mem_pkg::mem_rsp_t d_rsp,

    // memory side
    output logic              m_valid,
    output mem_pkg::mem_req_t m_pkt,
    input  mem_pkg::mem_rsp_t m_rsp
);
    localparam int LAT = `MEM_READ_LATENCY;

    logic           last_d;  // data client won the last grant
    logic [LAT-1:0] own_d;   // read owner per stage, 1 = data

    // ====================
    // round-robin select
    // ====================
    // the client not served last goes first
    assign f_gnt = f_req & (~d_req | last_d);
    assign d_gnt = d_req & (~f_req | ~last_d);

    assign m_valid = f_gnt | d_gnt;
    assign m_pkt   = d_gnt ? d_pkt : f_pkt;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_d <= 1'b0;
        end else if (m_valid) begin
            last_d <= d_gnt;
        end
    end

    // ====================
    // response routing
    // ====================
    // owner record runs beside the memory read pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            own_d <= '0;
        end else begin
            own_d[0] <= d_gnt;  // don't care for writes, no done follows
            for (int i = 1; i < LAT; i++) begin
                own_d[i] <= own_d[i-1];
            end
        end
    end

    assign f_rsp.done  = m_rsp.done & ~own_d[LAT-1];
    assign f_rsp.rdata = m_rsp.rdata;
    assign d_rsp.done  = m_rsp.done & own_d[LAT-1];
    assign d_rsp.rdata = m_rsp.rdata;

endmodule

// File: source/fetch_port.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module fetch_port (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       addr,
    input  logic              ren,
    output logic [31:0]       rdata,
    output logic              rvalid,
    input  logic              ready,
    output logic              req,
    output mem_pkg::mem_req_t req_pkt,
    input  logic              gnt,
    input  mem_pkg::mem_rsp_t rsp
);
    logic pending;  // granted, waiting for done

    // new read only while idle, never over held data
    assign req = ren & ~pending & ~rvalid;

    assign req_pkt.idx        = addr[`MEM_IDX_W+1:2];  // aligned down, upper bits wrap
    assign req_pkt.we         = 1'b0;
    assign req_pkt.wstrb      = 4'b0000;
    assign req_pkt.wdata.word = 32'h0;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (req && gnt) begin
                pending <= 1'b1;
            end else if (rsp.done) begin
                pending <= 1'b0;
            end

            // held until the receiver takes it
            if (rsp.done) begin
                rvalid <= 1'b1;
            end else if (rvalid && ready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp.done) begin
            rdata <= rsp.rdata;  // stable while rvalid is up
        end
    end

endmodule

// File: source/data_port.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module data_port (
    input  logic              clk,
    input  logic              rst,

    // read side
    input  logic [31:0]       raddr,
    input  logic              ren,
    output logic [31:0]       rdata,
    output logic              rvalid,
    input  logic              rready,

    // write side
    input  logic [31:0]       waddr,
    input  logic [31:0]       wdata,
    input  logic [2:0]        wlen,
    input  logic              wen,
    input  logic              wvalid,
    output logic              wready,

    // arbiter client
    output logic              req,
    output mem_pkg::mem_req_t req_pkt,
    input  logic              gnt,
    input  mem_pkg::mem_rsp_t rsp
);
    import mem_pkg::*;

    logic       wr_fire;
    logic       len_ok;
    logic [1:0] off;
    logic [3:0] wr_strb;
    mem_word_u  wr_lanes;

    logic       wr_pend;  // buffered write waiting for the memory
    mem_req_t   wr_pkt;

    logic       rd_req;
    mem_req_t   rd_pkt;
    logic       rd_gnt;

    assign off     = waddr[1:0];
    assign wr_fire = wvalid & wen & wready;

    // ====================
    // lane placement
    // ====================
    always_comb begin
        len_ok        = 1'b1;
        wr_strb       = 4'b0000;
        wr_lanes.word = 32'h0;
        case (wlen)
            `WLEN_BYTE: begin
                wr_strb[off]        = 1'b1;
                wr_lanes.bytes[off] = wdata[7:0];
            end
            `WLEN_HALF: begin  // aligned down to the halfword
                wr_strb[{off[1], 1'b0}]        = 1'b1;
                wr_strb[{off[1], 1'b1}]        = 1'b1;
                wr_lanes.bytes[{off[1], 1'b0}] = wdata[7:0];
                wr_lanes.bytes[{off[1], 1'b1}] = wdata[15:8];
            end
            `WLEN_WORD: begin
                wr_strb       = 4'b1111;
                wr_lanes.word = wdata;
            end
            default: len_ok = 1'b0;  // accepted, then dropped
        endcase
    end

    // ====================
    // write buffer
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_pend <= 1'b0;
            wready  <= 1'b1;
        end else if (wr_pend) begin
            if (gnt) begin
                wr_pend <= 1'b0;
                wready  <= 1'b1;
            end
        end else if (wr_fire && len_ok) begin
            wr_pend <= 1'b1;
            wready  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire && len_ok) begin
            wr_pkt.idx   <= waddr[`MEM_IDX_W+1:2];
            wr_pkt.we    <= 1'b1;
            wr_pkt.wstrb <= wr_strb;
            wr_pkt.wdata <= wr_lanes;
        end
    end

    // read side is a fetch channel that yields to the pending write
    assign rd_gnt = gnt & ~wr_pend;

    fetch_port u_rd (
        .clk     (clk),
        .rst     (rst),
        .addr    (raddr),
        .ren     (ren),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .ready   (rready),
        .req     (rd_req),
        .req_pkt (rd_pkt),
        .gnt     (rd_gnt),
        .rsp     (rsp)
    );

    assign req     = wr_pend | rd_req;
    assign req_pkt = wr_pend ? wr_pkt : rd_pkt;  // write first, it is older

endmodule

// File: source/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem (
    input  logic        clk,
    input  logic        rst,

    // instruction fetch
    input  logic [31:0] imem_addr,
    input  logic        imem_ren,
    output logic [31:0] imem_rdata,
    output logic        imem_rvalid,
    input  logic        imem_ready,

    // data read
    input  logic [31:0] dmem_raddr,
    input  logic        dmem_ren,
    output logic [31:0] dmem_rdata,
    output logic        dmem_rvalid,
    input  logic        dmem_rready,

    // data write
    input  logic [31:0] dmem_waddr,
    input  logic [31:0] dmem_wdata,
    input  logic [2:0]  dmem_wlen,
    input  logic        dmem_wen,
    input  logic        dmem_wvalid,
    output logic        dmem_wready
);
    import mem_pkg::*;

    logic     f_req;
    logic     f_gnt;
    mem_req_t f_pkt;
    mem_rsp_t f_rsp;

    logic     d_req;
    logic     d_gnt;
    mem_req_t d_pkt;
    mem_rsp_t d_rsp;

    logic     m_valid;
    mem_req_t m_pkt;
    mem_rsp_t m_rsp;

    fetch_port u_fetch (
        .clk     (clk),
        .rst     (rst),
        .addr    (imem_addr),
        .ren     (imem_ren),
        .rdata   (imem_rdata),
        .rvalid  (imem_rvalid),
        .ready   (imem_ready),
        .req     (f_req),
        .req_pkt (f_pkt),
        .gnt     (f_gnt),
        .rsp     (f_rsp)
    );

    data_port u_data (
        .clk     (clk),
        .rst     (rst),
        .raddr   (dmem_raddr),
        .ren     (dmem_ren),
        .rdata   (dmem_rdata),
        .rvalid  (dmem_rvalid),
        .rready  (dmem_rready),
        .waddr   (dmem_waddr),
        .wdata   (dmem_wdata),
        .wlen    (dmem_wlen),
        .wen     (dmem_wen),
        .wvalid  (dmem_wvalid),
        .wready  (dmem_wready),
        .req     (d_req),
        .req_pkt (d_pkt),
        .gnt     (d_gnt),
        .rsp     (d_rsp)
    );

    mem_arbiter u_arb (
        .clk     (clk),
        .rst     (rst),
        .f_req   (f_req),
        .f_pkt   (f_pkt),
        .f_gnt   (f_gnt),
        .f_rsp   (f_rsp),
        .d_req   (d_req),
        .d_pkt   (d_pkt),
        .d_gnt   (d_gnt),
        .d_rsp   (d_rsp),
        .m_valid (m_valid),
        .m_pkt   (m_pkt),
        .m_rsp   (m_rsp)
    );

    sram_bank u_sram (
        .clk     (clk),
        .rst     (rst),
        .valid   (m_valid),
        .req_pkt (m_pkt),
        .rsp     (m_rsp)
    );

endmodule

// File: tb/tb_mem_subsystem.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module tb_mem_subsystem;

    // init 48, lanes 16, invalid 2, concurrent 40, mix 200
    localparam int N_TRANS     = 48 + 16 + 2 + 40 + 200;
    localparam int CYCLE_LIMIT = 40 * N_TRANS + 200;

    logic        clk;
    logic        rst;
    logic [31:0] imem_addr;
    logic        imem_ren;
    logic [31:0] imem_rdata;
    logic        imem_rvalid;
    logic        imem_ready;
    logic [31:0] dmem_raddr;
    logic        dmem_ren;
    logic [31:0] dmem_rdata;
    logic        dmem_rvalid;
    logic        dmem_rready;
    logic [31:0] dmem_waddr;
    logic [31:0] dmem_wdata;
    logic [2:0]  dmem_wlen;
    logic        dmem_wen;
    logic        dmem_wvalid;
    logic        dmem_wready;

    logic [31:0] shadow [`MEM_DEPTH_WORDS];
    logic [31:0] f_addr_q;  // address of the fetch in flight
    logic [31:0] d_addr_q;
    logic        f_hold = 1'b0;
    logic        d_hold = 1'b0;
    logic [31:0] f_prev;
    logic [31:0] d_prev;
    integer      seed;
    int          cmp_errors = 0;
    int          seq_errors = 0;
    int          checks = 0;
    int          reads = 0;
    int          cycles = 0;

    mem_subsystem uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // expected word after a store, by byte lane
    function automatic logic [31:0] ref_write_merge(input logic [31:0] old,
            input logic [31:0] d, input logic [31:0] a, input logic [2:0] len);
        logic [31:0] w;
        w = old;
        case (len)
            `WLEN_BYTE: w[{a[1:0], 3'b000} +: 8] = d[7:0];
            `WLEN_HALF: w[{a[1], 4'b0000} +: 16] = d[15:0];  // halfword aligned down
            `WLEN_WORD: w = d;
            default:    w = old;
        endcase
        return w;
    endfunction

    // word k of the test pool, random upper bits to exercise the wrap
    function automatic logic [31:0] pool_addr(input int k);
        logic [31:0] r;
        r = $random(seed);
        return {r[31:10], 8'(k), r[1:0]};
    endfunction

    function automatic logic rvalid_of(input bit ch);
        return ch ? dmem_rvalid : imem_rvalid;
    endfunction

    task automatic write_mem(input logic [31:0] a, input logic [31:0] d,
            input logic [2:0] len);
        logic ok;
        @(posedge clk);
        dmem_waddr  <= a;
        dmem_wdata  <= d;
        dmem_wlen   <= len;
        dmem_wen    <= 1'b1;
        dmem_wvalid <= 1'b1;
        do begin
            @(negedge clk);
            ok = dmem_wready;
            @(posedge clk);
        end while (!ok);
        dmem_wvalid <= 1'b0;
        dmem_wen    <= 1'b0;
        shadow[a[`MEM_IDX_W+1:2]] = ref_write_merge(shadow[a[`MEM_IDX_W+1:2]], d, a, len);
        do @(negedge clk); while (!dmem_wready);  // committed once wready is back
    endtask

    // ch 1 = data read side, 0 = fetch
    task automatic read_mem(input bit ch, input logic [31:0] a, input bit bp,
            output int lat);
        int span;
        span = 0;
        if (bp)
            span = $unsigned($random(seed)) % 6;
        reads++;
        @(posedge clk);
        if (ch) begin
            d_addr_q = a;
            dmem_raddr  <= a;
            dmem_ren    <= 1'b1;
            dmem_rready <= (span == 0);
        end else begin
            f_addr_q = a;
            imem_addr  <= a;
            imem_ren   <= 1'b1;
            imem_ready <= (span == 0);
        end
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end while (!rvalid_of(ch));
        @(posedge clk);
        if (ch)
            dmem_ren <= 1'b0;
        else
            imem_ren <= 1'b0;
        repeat (span) @(posedge clk);  // back-pressure span
        if (ch)
            dmem_rready <= 1'b1;
        else
            imem_ready <= 1'b1;
        do @(negedge clk); while (rvalid_of(ch));
    endtask

    // ====================
    // comparing process
    // ====================
    always @(negedge clk) begin
        if (!rst) begin
            if (imem_rvalid && imem_ready) begin
                checks++;
                if (imem_rdata !== shadow[f_addr_q[`MEM_IDX_W+1:2]]) begin
                    cmp_errors++;
                    $display("FAILED imem_rdata expected %h got %h",
                             shadow[f_addr_q[`MEM_IDX_W+1:2]], imem_rdata);
                end
            end
            if (dmem_rvalid && dmem_rready) begin
                checks++;
                if (dmem_rdata !== shadow[d_addr_q[`MEM_IDX_W+1:2]]) begin
                    cmp_errors++;
                    $display("FAILED dmem_rdata expected %h got %h",
                             shadow[d_addr_q[`MEM_IDX_W+1:2]], dmem_rdata);
                end
            end
            if (f_hold && (!imem_rvalid || imem_rdata !== f_prev)) begin
                cmp_errors++;
                $display("fetch read data or valid changed while imem_ready was low");
            end
            if (d_hold && (!dmem_rvalid || dmem_rdata !== d_prev)) begin
                cmp_errors++;
                $display("data read data or valid changed while dmem_rready was low");
            end
            f_hold = imem_rvalid && !imem_ready;
            d_hold = dmem_rvalid && !dmem_rready;
            f_prev = imem_rdata;
            d_prev = dmem_rdata;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, run did not finish", cycles);
            $display("errors: %0d compare, %0d sequence", cmp_errors, seq_errors);
            $display("test failed");
            $finish;
        end
    end

    // ====================
    // stimulus
    // ====================
    initial begin
        int          lat;
        int          lat_f;
        int          lat_d;
        logic [31:0] fa;
        logic [31:0] da;
        logic [2:0]  len;
        seed = 32'h5da1_dea1;
        rst = 1'b1;
        imem_addr = 32'h0;
        imem_ren = 1'b0;
        imem_ready = 1'b1;
        dmem_raddr = 32'h0;
        dmem_ren = 1'b0;
        dmem_rready = 1'b1;
        dmem_waddr = 32'h0;
        dmem_wdata = 32'h0;
        dmem_wlen = `WLEN_WORD;
        dmem_wen = 1'b0;
        dmem_wvalid = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        if (imem_rvalid !== 1'b0 || dmem_rvalid !== 1'b0 || dmem_wready !== 1'b1) begin
            seq_errors++;
            $display("FAILED rvalid/wready after reset: imem_rvalid %h dmem_rvalid %h dmem_wready %h",
                     imem_rvalid, dmem_rvalid, dmem_wready);
        end

        // fill the pool with whole words
        for (int k = 0; k < 16; k++)
            write_mem(pool_addr(k), $random(seed), `WLEN_WORD);
        for (int k = 0; k < 16; k++) begin
            read_mem(1'b1, pool_addr(k), 1'b0, lat);
            if (lat != 3) begin
                seq_errors++;
                $display("FAILED dmem_rvalid delay expected %h got %h", 3, lat);
            end
            read_mem(1'b0, pool_addr(k), 1'b0, lat);
            if (lat != 3) begin
                seq_errors++;
                $display("FAILED imem_rvalid delay expected %h got %h", 3, lat);
            end
        end

        // sub-word stores at every lane offset
        for (int o = 0; o < 4; o++) begin
            fa = (32'(o + 1) << 2) | 32'(o);
            write_mem(fa, $random(seed), `WLEN_BYTE);
            read_mem(1'b1, fa, 1'b0, lat);
            write_mem(fa, $random(seed), `WLEN_HALF);
            read_mem(1'b0, fa, 1'b0, lat);
        end

        da = pool_addr(5);
        write_mem(da, 32'hdead_beef, 3'b011);  // not one-hot
        read_mem(1'b1, da, 1'b0, lat);

        for (int n = 0; n < 20; n++) begin
            fa = pool_addr($unsigned($random(seed)) % 16);
            da = pool_addr($unsigned($random(seed)) % 16);
            fork
                read_mem(1'b0, fa, 1'b1, lat_f);
                read_mem(1'b1, da, 1'b1, lat_d);
            join
        end

        // random mix
        for (int n = 0; n < 200; n++) begin
            fa = pool_addr($unsigned($random(seed)) % 16);
            da = pool_addr($unsigned($random(seed)) % 16);
            case ($unsigned($random(seed)) % 4)
                0: begin
                    case ($unsigned($random(seed)) % 4)
                        0: len = `WLEN_BYTE;
                        1: len = `WLEN_HALF;
                        2: len = `WLEN_WORD;
                        default: len = 3'b110;
                    endcase
                    write_mem(da, $random(seed), len);
                end
                1: read_mem(1'b1, da, 1'b1, lat);
                2: read_mem(1'b0, fa, 1'b1, lat);
                default: begin
                    fork
                        read_mem(1'b0, fa, 1'b1, lat_f);
                        read_mem(1'b1, da, 1'b1, lat_d);
                    join
                end
            endcase
        end

        repeat (4) @(posedge clk);
        if (checks != reads) begin
            seq_errors++;
            $display("%0d reads were issued but %0d read handshakes were checked", reads, checks);
        end
        $display("errors: %0d compare, %0d sequence, %0d reads checked",
                 cmp_errors, seq_errors, checks);
        if (cmp_errors + seq_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: project.f
+incdir+include
source/mem_pkg.sv
source/sram_bank.sv
source/mem_arbiter.sv
source/fetch_port.sv
source/data_port.sv
source/mem_subsystem.sv
tb/tb_mem_subsystem.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP      := tb_mem_subsystem
FILELIST := project.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := test passed
SOURCES  := $(wildcard include/*.svh source/*.sv tb/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(TOOL) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
